// File: hdl/soc_bus_pkg.sv
package soc_bus_pkg;

  // data bus widths
  localparam int BUS_ADDR_WIDTH = 32;
  localparam int BUS_DATA_WIDTH = 32;
  localparam int BUS_MASK_WIDTH = BUS_DATA_WIDTH / 8;  // one bit per byte lane

  typedef logic [BUS_ADDR_WIDTH-1:0] bus_addr_t;
  typedef logic [BUS_DATA_WIDTH-1:0] bus_data_t;
  typedef logic [BUS_MASK_WIDTH-1:0] bus_mask_t;

  // synchroniser depths
  localparam int RST_SYNC_STAGES = 3;
  localparam int KEY_SYNC_STAGES = 2;

  // board i/o
  localparam int LED_WIDTH = 8;
  localparam int KEY_WIDTH = 2;

  // data ram, word index taken from address bits 11:2
  localparam int RAM_WORDS     = 1024;
  localparam int RAM_IDX_LSB   = 2;
  localparam int RAM_IDX_WIDTH = $clog2(RAM_WORDS);

  // region select field of the byte address
  localparam int REGION_MSB = 31;
  localparam int REGION_LSB = 30;

  typedef enum logic [1:0] {
    REGION_LED      = 2'b00,
    REGION_UNMAPPED = 2'b01,
    REGION_RAM      = 2'b10,
    REGION_KEYS     = 2'b11
  } region_t;

  localparam bus_addr_t LED_BASE  = 32'h0000_0000;
  localparam bus_addr_t RAM_BASE  = 32'h8000_0000;
  localparam bus_addr_t KEYS_BASE = 32'hC000_0000;

  // returned on a read from the hole in the map
  localparam bus_data_t BUS_ERR_DATA = 32'hDEAD_BEEF;

endpackage

// File: hdl/reset_sync.sv
module reset_sync #(
  parameter int STAGES = 2
) (
  input  logic clk,
  input  logic i_arst_n,
  output logic o_rst_n
);

  logic [STAGES-1:0] sync_q;

  // assert at once, release after STAGES edges
  always_ff @(posedge clk or negedge i_arst_n)
  begin
    if (!i_arst_n)
    begin
      sync_q <= '0;
    end
    else
    begin
      sync_q <= {sync_q[STAGES-2:0], 1'b1};
    end
  end

  assign o_rst_n = sync_q[STAGES-1];

endmodule

// File: hdl/bus_router.sv
module bus_router
  import soc_bus_pkg::*;
(
  input  logic      clk,
  input  logic      i_rst_n,

  input  logic      i_bus_req,
  input  logic      i_bus_write,
  input  bus_addr_t i_bus_addr,

  output logic      o_bus_ack,
  output bus_data_t o_bus_rdata,

  output logic      o_ram_req,
  input  logic      i_ram_ack,
  input  bus_data_t i_ram_rdata,

  output logic      o_led_req,
  input  logic      i_led_ack,
  input  bus_data_t i_led_rdata,

  output logic      o_key_req,
  input  logic      i_key_ack,
  input  bus_data_t i_key_rdata
);

  region_t   region;
  region_t   region_q;     // region of the outstanding transfer
  logic      err_ack_q;
  logic      err_rd_q;
  logic      sel_ack;
  bus_data_t sel_data;

  assign region = region_t'(i_bus_addr[REGION_MSB:REGION_LSB]);

  // request decode, same cycle as the master's pulse
  assign o_ram_req = i_bus_req && (region == REGION_RAM);
  assign o_led_req = i_bus_req && (region == REGION_LED);
  assign o_key_req = i_bus_req && (region == REGION_KEYS);

  always_ff @(posedge clk or negedge i_rst_n)
  begin
    if (!i_rst_n)
    begin
      region_q  <= REGION_UNMAPPED;
      err_ack_q <= 1'b0;
      err_rd_q  <= 1'b0;
    end
    else
    begin
      if (i_bus_req)
      begin
        region_q <= region;
      end
      // nothing behind the hole, answer here
      err_ack_q <= i_bus_req && (region == REGION_UNMAPPED);
      err_rd_q  <= i_bus_req && (region == REGION_UNMAPPED) && !i_bus_write;
    end
  end

  // return path follows the stored region only
  always_comb
  begin
    case (region_q)
      REGION_RAM:
      begin
        sel_ack  = i_ram_ack;
        sel_data = i_ram_rdata;
      end
      REGION_LED:
      begin
        sel_ack  = i_led_ack;
        sel_data = i_led_rdata;
      end
      REGION_KEYS:
      begin
        sel_ack  = i_key_ack;
        sel_data = i_key_rdata;
      end
      default:
      begin
        sel_ack  = err_ack_q;
        sel_data = err_rd_q ? BUS_ERR_DATA : '0;
      end
    endcase
  end

  assign o_bus_ack   = sel_ack;
  assign o_bus_rdata = sel_ack ? sel_data : '0;  // quiet between transfers

endmodule

// File: hdl/data_ram.sv
module data_ram
  import soc_bus_pkg::*;
(
  input  logic      clk,
  input  logic      i_rst_n,

  input  logic      i_req,
  input  logic      i_write,
  input  bus_addr_t i_addr,
  input  bus_data_t i_wdata,
  input  bus_mask_t i_wr_mask,
  input  bus_mask_t i_rd_mask,

  output logic      o_ack,
  output bus_data_t o_rdata
);

  bus_data_t                mem [RAM_WORDS];
  logic [RAM_IDX_WIDTH-1:0] idx;
  bus_data_t                rd_lanes;
  bus_data_t                rdata_q;

  assign idx = i_addr[RAM_IDX_LSB +: RAM_IDX_WIDTH];

  // byte mask to bit mask
  always_comb
  begin
    for (int b = 0; b < BUS_MASK_WIDTH; b++)
    begin
      rd_lanes[b*8 +: 8] = {8{i_rd_mask[b]}};
    end
  end

  always_ff @(posedge clk)
  begin
    if (i_req)
    begin
      if (i_write)
      begin
        for (int b = 0; b < BUS_MASK_WIDTH; b++)
        begin
          if (i_wr_mask[b])
          begin
            mem[idx][b*8 +: 8] <= i_wdata[b*8 +: 8];
          end
        end
        rdata_q <= '0;
      end
      else
      begin
        rdata_q <= mem[idx] & rd_lanes;  // unselected lanes read as zero
      end
    end
  end

  always_ff @(posedge clk or negedge i_rst_n)
  begin
    if (!i_rst_n)
    begin
      o_ack <= 1'b0;
    end
    else
    begin
      o_ack <= i_req;
    end
  end

  assign o_rdata = rdata_q;

endmodule

// File: hdl/led_port.sv
module led_port
  import soc_bus_pkg::*;
(
  input  logic                 clk,
  input  logic                 i_rst_n,

  input  logic                 i_req,
  input  logic                 i_write,
  input  bus_data_t            i_wdata,
  input  bus_mask_t            i_wr_mask,

  output logic                 o_ack,
  output bus_data_t            o_rdata,
  output logic [LED_WIDTH-1:0] o_led
);

  logic [LED_WIDTH-1:0] led_q;
  bus_data_t            rdata_q;

  always_ff @(posedge clk or negedge i_rst_n)
  begin
    if (!i_rst_n)
    begin
      led_q <= '0;
      o_ack <= 1'b0;
    end
    else
    begin
      o_ack <= i_req;
      if (i_req && i_write && i_wr_mask[0])  // only lane 0 holds led bits
      begin
        led_q <= i_wdata[LED_WIDTH-1:0];
      end
    end
  end

  // read back, zero extended
  always_ff @(posedge clk)
  begin
    if (i_req)
    begin
      rdata_q <= i_write ? '0 : {{(BUS_DATA_WIDTH-LED_WIDTH){1'b0}}, led_q};
    end
  end

  assign o_rdata = rdata_q;
  assign o_led   = led_q;

endmodule

// File: hdl/key_port.sv
module key_port
  import soc_bus_pkg::*;
(
  input  logic                 clk,
  input  logic                 i_rst_n,

  input  logic                 i_req,
  input  logic                 i_write,

  output logic                 o_ack,
  output bus_data_t            o_rdata,

  input  logic [KEY_WIDTH-1:0] i_key
);

  logic [KEY_SYNC_STAGES-1:0][KEY_WIDTH-1:0] key_sync;
  logic [KEY_WIDTH-1:0]                      key_level;
  bus_data_t                                 rdata_q;

  // keys are asynchronous to clk
  always_ff @(posedge clk or negedge i_rst_n)
  begin
    if (!i_rst_n)
    begin
      key_sync <= '0;
      o_ack    <= 1'b0;
    end
    else
    begin
      key_sync[0] <= i_key;
      for (int s = 1; s < KEY_SYNC_STAGES; s++)
      begin
        key_sync[s] <= key_sync[s-1];
      end
      o_ack <= i_req;
    end
  end

  assign key_level = key_sync[KEY_SYNC_STAGES-1];

  // read only, a write just gets its ack
  always_ff @(posedge clk)
  begin
    if (i_req)
    begin
      rdata_q <= i_write ? '0 : {{(BUS_DATA_WIDTH-KEY_WIDTH){1'b0}}, key_level};
    end
  end

  assign o_rdata = rdata_q;

endmodule

// File: hdl/soc_fabric.sv
module soc_fabric
  import soc_bus_pkg::*;
(
  input  logic                 clk,
  input  logic                 i_arst_n,

  // bus master side
  input  logic                 i_bus_req,
  input  logic                 i_bus_write,
  input  bus_addr_t            i_bus_addr,
  input  bus_data_t            i_bus_wdata,
  input  bus_mask_t            i_bus_wr_mask,
  input  bus_mask_t            i_bus_rd_mask,

  output logic                 o_bus_ack,
  output bus_data_t            o_bus_rdata,

  // board i/o
  output logic [LED_WIDTH-1:0] o_led,
  input  logic [KEY_WIDTH-1:0] i_key
);

  logic      rst_n;

  logic      ram_req;
  logic      ram_ack;
  bus_data_t ram_rdata;

  logic      led_req;
  logic      led_ack;
  bus_data_t led_rdata;

  logic      key_req;
  logic      key_ack;
  bus_data_t key_rdata;

  reset_sync #(
    .STAGES (RST_SYNC_STAGES)
  ) i_reset_sync (
    .clk      (clk),
    .i_arst_n (i_arst_n),
    .o_rst_n  (rst_n)
  );

  bus_router i_bus_router (
    .clk         (clk),
    .i_rst_n     (rst_n),
    .i_bus_req   (i_bus_req),
    .i_bus_write (i_bus_write),
    .i_bus_addr  (i_bus_addr),
    .o_bus_ack   (o_bus_ack),
    .o_bus_rdata (o_bus_rdata),
    .o_ram_req   (ram_req),
    .i_ram_ack   (ram_ack),
    .i_ram_rdata (ram_rdata),
    .o_led_req   (led_req),
    .i_led_ack   (led_ack),
    .i_led_rdata (led_rdata),
    .o_key_req   (key_req),
    .i_key_ack   (key_ack),
    .i_key_rdata (key_rdata)
  );

  // write side of the bus is shared by all targets
  data_ram i_data_ram (
    .clk       (clk),
    .i_rst_n   (rst_n),
    .i_req     (ram_req),
    .i_write   (i_bus_write),
    .i_addr    (i_bus_addr),
    .i_wdata   (i_bus_wdata),
    .i_wr_mask (i_bus_wr_mask),
    .i_rd_mask (i_bus_rd_mask),
    .o_ack     (ram_ack),
    .o_rdata   (ram_rdata)
  );

  led_port i_led_port (
    .clk       (clk),
    .i_rst_n   (rst_n),
    .i_req     (led_req),
    .i_write   (i_bus_write),
    .i_wdata   (i_bus_wdata),
    .i_wr_mask (i_bus_wr_mask),
    .o_ack     (led_ack),
    .o_rdata   (led_rdata),
    .o_led     (o_led)
  );

  key_port i_key_port (
    .clk     (clk),
    .i_rst_n (rst_n),
    .i_req   (key_req),
    .i_write (i_bus_write),
    .o_ack   (key_ack),
    .o_rdata (key_rdata),
    .i_key   (i_key)
  );

endmodule

// File: tests/tb_bus_tasks.svh
`ifndef TB_BUS_TASKS_SVH
`define TB_BUS_TASKS_SVH

localparam int unsigned RANDOM_SEED = 32'h5facdf08;
localparam int RESET_CYCLES    = 3;
localparam int RAM_XFERS       = 200;
localparam int OTHER_XFERS     = 24;  // led, keys and unmapped, upper bound
localparam int KEY_ROUNDS      = 4;
localparam int ACK_WAIT_CYCLES = 8;
localparam int WATCHDOG_CYCLES = (RAM_XFERS + OTHER_XFERS) * 4 + 200;

localparam bus_addr_t UNMAPPED_BASE = 32'h4000_0000;

int        errors = 0;
int        checks = 0;
int        xfers  = 0;
int        test_errors_start = 0;
string     test_name = "none";

// reference copy of the data ram, only words the bus has written
bus_data_t ram_model [int];
int        written [$];

function automatic bus_data_t lane_bits(input bus_mask_t mask);
  bus_data_t bits;
  for (int b = 0; b < BUS_MASK_WIDTH; b++)
  begin
    bits[b*8 +: 8] = mask[b] ? 8'hFF : 8'h00;
  end
  return bits;
endfunction

function automatic void model_write(input int idx, input bus_data_t data, input bus_mask_t mask);
  bus_data_t old_word;
  old_word       = ram_model.exists(idx) ? ram_model[idx] : '0;
  ram_model[idx] = (old_word & ~lane_bits(mask)) | (data & lane_bits(mask));
endfunction

function automatic bus_data_t model_read(input int idx, input bus_mask_t mask);
  return ram_model[idx] & lane_bits(mask);
endfunction

function automatic bus_addr_t ram_addr(input int idx);
  return RAM_BASE | (bus_addr_t'(idx) << RAM_IDX_LSB);
endfunction

// one request pulse, then wait for the single ack
task automatic bus_xfer(
  input  logic      is_write,
  input  bus_addr_t addr,
  input  bus_data_t wdata,
  input  bus_mask_t wr_mask,
  input  bus_mask_t rd_mask,
  output bus_data_t rdata
);
  int waited;
  @(negedge clk);
  i_bus_req     = 1'b1;
  i_bus_write   = is_write;
  i_bus_addr    = addr;
  i_bus_wdata   = wdata;
  i_bus_wr_mask = wr_mask;
  i_bus_rd_mask = rd_mask;
  @(negedge clk);
  i_bus_req = 1'b0;
  waited    = 0;
  while (!o_bus_ack && waited < ACK_WAIT_CYCLES)
  begin
    @(negedge clk);
    waited++;
  end
  if (!o_bus_ack)
  begin
    $display("no acknowledge for address 0x%h in test %s", addr, test_name);
    errors++;
  end
  rdata = o_bus_rdata;
  xfers++;
endtask

task automatic bus_write(input bus_addr_t addr, input bus_data_t data, input bus_mask_t mask);
  bus_data_t rdata;
  bus_xfer(1'b1, addr, data, mask, '0, rdata);
  check_value("write return data", '0, rdata);  // writes return zero
endtask

task automatic bus_read(input bus_addr_t addr, input bus_mask_t mask, output bus_data_t rdata);
  bus_xfer(1'b0, addr, '0, '0, mask, rdata);
endtask

`endif

// File: tests/tb_soc_fabric.sv
module tb_soc_fabric
  import soc_bus_pkg::*;
;

  logic                 clk = 1'b0;
  logic                 i_arst_n;
  logic                 i_bus_req;
  logic                 i_bus_write;
  bus_addr_t            i_bus_addr;
  bus_data_t            i_bus_wdata;
  bus_mask_t            i_bus_wr_mask;
  bus_mask_t            i_bus_rd_mask;
  logic                 o_bus_ack;
  bus_data_t            o_bus_rdata;
  logic [LED_WIDTH-1:0] o_led;
  logic [KEY_WIDTH-1:0] i_key;
  logic [LED_WIDTH-1:0] led_expected;

  `include "tb_bus_tasks.svh"

  soc_fabric i_soc_fabric (
    .clk           (clk),
    .i_arst_n      (i_arst_n),
    .i_bus_req     (i_bus_req),
    .i_bus_write   (i_bus_write),
    .i_bus_addr    (i_bus_addr),
    .i_bus_wdata   (i_bus_wdata),
    .i_bus_wr_mask (i_bus_wr_mask),
    .i_bus_rd_mask (i_bus_rd_mask),
    .o_bus_ack     (o_bus_ack),
    .o_bus_rdata   (o_bus_rdata),
    .o_led         (o_led),
    .i_key         (i_key)
  );

  always #10 clk = ~clk;

  // one ack exactly one cycle after each request
  ack_follows_req: assert property (@(posedge clk) disable iff (!i_arst_n)
    o_bus_ack == $past(i_bus_req))
  else
  begin
    $display("bus ack out of step with the request in test %s", test_name);
    errors++;
  end

  task automatic check_value(input string what, input bus_data_t expected,
                             input bus_data_t actual);
    checks++;
    assert (actual === expected)
    else
    begin
      $display("Mismatch in %s, %s: expected 0x%h, actual 0x%h",
               test_name, what, expected, actual);
      errors++;
    end
  endtask

  task automatic begin_test(input string name);
    test_name         = name;
    test_errors_start = errors;
  endtask

  task automatic report_test();
    $display("test %-16s done, %0d errors", test_name, errors - test_errors_start);
  endtask

  task automatic apply_reset();
    begin_test("reset_state");
    i_arst_n = 1'b0;
    repeat (RESET_CYCLES)
    begin
      @(negedge clk);
      check_value("ack in reset", '0, o_bus_ack);
      check_value("led in reset", '0, o_led);
    end
    i_arst_n = 1'b1;
    repeat (RST_SYNC_STAGES + 1) @(negedge clk);  // release through the sync chain
    check_value("ack after reset", '0, o_bus_ack);
    check_value("rdata after reset", '0, o_bus_rdata);
    check_value("led after reset", '0, o_led);
    led_expected = '0;
    report_test();
  endtask

  task automatic exercise_ram_masks();
    int        idx;
    bus_data_t data;
    bus_mask_t mask;
    bus_data_t rdata;
    begin_test("ram_byte_masks");
    for (int n = 0; n < RAM_XFERS; n++)
    begin
      if (written.size() == 0 || $urandom_range(1) == 0)
      begin
        idx  = $urandom_range(RAM_WORDS - 1);
        data = $urandom;
        mask = bus_mask_t'($urandom);
        if (!ram_model.exists(idx))
        begin
          mask = '1;  // first touch fills the whole word
          written.push_back(idx);
        end
        bus_write(ram_addr(idx), data, mask);
        model_write(idx, data, mask);
      end
      else
      begin
        idx  = written[$urandom_range(written.size() - 1)];
        mask = bus_mask_t'($urandom);
        bus_read(ram_addr(idx), mask, rdata);
        check_value("ram read", model_read(idx, mask), rdata);
      end
    end
    report_test();
  endtask

  task automatic exercise_led_register();
    bus_data_t data;
    bus_data_t rdata;
    begin_test("led_register");
    data = $urandom;
    if (data[LED_WIDTH-1:0] == led_expected)
    begin
      data[0] = ~data[0];  // must move o_led off its reset value
    end
    bus_write(LED_BASE, data, bus_mask_t'($urandom) | 4'b0001);
    led_expected = data[LED_WIDTH-1:0];
    check_value("led after lane 0 write", led_expected, o_led);
    data = $urandom;
    data[LED_WIDTH-1:0] = ~led_expected;  // would show up if taken
    bus_write(LED_BASE, data, bus_mask_t'($urandom) & 4'b1110);
    check_value("led after write without lane 0", led_expected, o_led);
    bus_read(LED_BASE, '1, rdata);
    check_value("led read back", led_expected, rdata);
    report_test();
  endtask

  task automatic exercise_keys();
    logic [KEY_WIDTH-1:0] key_value;
    bus_data_t            rdata;
    begin_test("key_port");
    for (int round = 0; round < KEY_ROUNDS; round++)
    begin
      @(negedge clk);
      key_value = KEY_WIDTH'($urandom);
      i_key     = key_value;
      repeat (KEY_SYNC_STAGES + 1) @(negedge clk);
      bus_read(KEYS_BASE, '1, rdata);
      check_value("key level", key_value, rdata);
      bus_write(KEYS_BASE, $urandom, '1);
      bus_read(KEYS_BASE, '1, rdata);
      check_value("key level after write", key_value, rdata);
    end
    report_test();
  endtask

  task automatic probe_unmapped();
    int        idx;
    bus_data_t data;
    bus_data_t rdata;
    begin_test("unmapped_region");
    bus_read(UNMAPPED_BASE | (bus_addr_t'($urandom) & 32'h3FFF_FFFC), '1, rdata);
    check_value("unmapped read", BUS_ERR_DATA, rdata);
    // same low address bits as a live ram word and the led register
    idx  = written[0];
    data = ~ram_model[idx];
    data[LED_WIDTH-1:0] = ~led_expected;  // visible on o_led if routed there
    bus_write(UNMAPPED_BASE | (bus_addr_t'(idx) << RAM_IDX_LSB), data, '1);
    bus_read(ram_addr(idx), '1, rdata);
    check_value("ram after unmapped write", model_read(idx, '1), rdata);
    check_value("led after unmapped write", led_expected, o_led);
    bus_read(LED_BASE, '1, rdata);
    check_value("led read after unmapped write", led_expected, rdata);
    report_test();
  endtask

  initial
  begin
    void'($urandom(RANDOM_SEED));
    i_arst_n      = 1'b0;
    i_bus_req     = 1'b0;
    i_bus_write   = 1'b0;
    i_bus_addr    = '0;
    i_bus_wdata   = '0;
    i_bus_wr_mask = '0;
    i_bus_rd_mask = '0;
    i_key         = '0;
    apply_reset();
    exercise_ram_masks();
    exercise_led_register();
    exercise_keys();
    probe_unmapped();
    $display("checks %0d, errors %0d, transfers %0d", checks, errors, xfers);
    if (errors == 0)
    begin
      $display("RESULT: PASS");
    end
    else
    begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

  // limit scales with the number of bus transfers
  initial
  begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("watchdog expired after %0d cycles, tests did not complete", WATCHDOG_CYCLES);
    $display("RESULT: FAIL");
    $finish;
  end

endmodule

// File: soc_fabric.f
+incdir+tests
hdl/soc_bus_pkg.sv
hdl/reset_sync.sv
hdl/bus_router.sv
hdl/data_ram.sv
hdl/led_port.sv
hdl/key_port.sv
hdl/soc_fabric.sv
tests/tb_soc_fabric.sv
